/* src/aes_pkg.sv */
// Shared widths, register map, FSM states and bus types for the AES-128 APB peripheral
package aes_pkg;

    localparam int BYTE_W     = 8;
    localparam int WORD_W     = 32;
    localparam int BLOCK_W    = 128;
    localparam int NUM_ROUNDS = 10;
    localparam int ADDR_W     = 6;

    // round constant of the first key expansion
    localparam logic [BYTE_W-1:0] RCON_FIRST = 8'h01;

    // byte 0 is the most significant byte, FIPS-197 input order
    typedef logic [0:BLOCK_W/BYTE_W-1][BYTE_W-1:0] aes_block_t;

    typedef logic [WORD_W-1:0] aes_word_t;

    // word offsets, the highest word of each group carries block bytes 0..3
    typedef enum logic [ADDR_W-1:0] {
        PTEXT0 = 6'd0,
        PTEXT1 = 6'd4,
        PTEXT2 = 6'd8,
        PTEXT3 = 6'd12,
        KEY0   = 6'd16,
        KEY1   = 6'd20,
        KEY2   = 6'd24,
        KEY3   = 6'd28,
        CTEXT0 = 6'd32,
        CTEXT1 = 6'd36,
        CTEXT2 = 6'd40,
        CTEXT3 = 6'd44,
        CTRL   = 6'd48,
        STATUS = 6'd52
    } aes_reg_e;

    typedef enum logic {
        IDLE,
        BUSY
    } core_state_e;

    // APB request side, bundled
    typedef struct packed {
        logic              sel;
        logic              enable;
        logic              write;
        logic [ADDR_W-1:0] addr;
        aes_word_t         wdata;
    } apb_req_t;

endpackage

/* src/aes_sbox.sv */
// AES S-box for one byte, composite field GF(2^4) inversion followed by the affine map
`timescale 1ns/100ps
module aes_sbox (
    input  logic [aes_pkg::BYTE_W-1:0] in_i,
    output logic [aes_pkg::BYTE_W-1:0] out_o
);

    function automatic logic [3:0] gf4_mul(input logic [3:0] a, input logic [3:0] b);
        logic [3:0] p;
        p[0] = (a[0] & b[0]) ^ (a[3] & b[1]) ^ (a[2] & b[2]) ^ (a[1] & b[3]);
        p[1] = (a[1] & b[0]) ^ ((a[0] ^ a[3]) & b[1]) ^ ((a[2] ^ a[3]) & b[2])
             ^ ((a[1] ^ a[2]) & b[3]);
        p[2] = (a[2] & b[0]) ^ (a[1] & b[1]) ^ ((a[0] ^ a[3]) & b[2]) ^ ((a[2] ^ a[3]) & b[3]);
        p[3] = (a[3] & b[0]) ^ (a[2] & b[1]) ^ (a[1] & b[2]) ^ ((a[0] ^ a[3]) & b[3]);
        return p;
    endfunction

    function automatic logic [3:0] gf4_sq(input logic [3:0] a);
        return {a[3], a[1] ^ a[3], a[2], a[0] ^ a[2]};
    endfunction

    logic [3:0] ah, al, ah_sq, sq_e, xin, inv, qmh, qml;
    logic [7:0] gf;
    logic       inv_t, qm_a, qm_b;

    // isomorphic map into the pair ah*x + al
    assign ah[3] = in_i[5] ^ in_i[7];
    assign ah[2] = in_i[5] ^ in_i[7] ^ in_i[2] ^ in_i[3];
    assign ah[1] = in_i[1] ^ in_i[7] ^ in_i[4] ^ in_i[6];
    assign ah[0] = in_i[4] ^ in_i[6] ^ in_i[5];
    assign al[3] = in_i[2] ^ in_i[4];
    assign al[2] = in_i[1] ^ in_i[7];
    assign al[1] = in_i[1] ^ in_i[2];
    assign al[0] = in_i[4] ^ in_i[6] ^ in_i[0] ^ in_i[5];

    // ah^2 scaled by the field constant e
    assign ah_sq = gf4_sq(ah);
    assign sq_e  = {^ah_sq, ah_sq[0] ^ ah_sq[1] ^ ah_sq[2], ah_sq[0] ^ ah_sq[1],
                    ah_sq[1] ^ ah_sq[2] ^ ah_sq[3]};
    assign xin   = sq_e ^ gf4_sq(al) ^ gf4_mul(ah, al);

    // GF(2^4) inverse of xin
    assign inv_t  = xin[1] ^ xin[2] ^ xin[3] ^ (xin[1] & xin[2] & xin[3]);
    assign inv[0] = inv_t ^ xin[0] ^ (xin[0] & xin[2]) ^ (xin[1] & xin[2])
                  ^ (xin[0] & xin[1] & xin[2]);
    assign inv[1] = (xin[0] & xin[1]) ^ (xin[0] & xin[2]) ^ (xin[1] & xin[2]) ^ xin[3]
                  ^ (xin[1] & xin[3]) ^ (xin[0] & xin[1] & xin[3]);
    assign inv[2] = (xin[0] & xin[1]) ^ xin[2] ^ (xin[0] & xin[2]) ^ xin[3]
                  ^ (xin[0] & xin[3]) ^ (xin[0] & xin[2] & xin[3]);
    assign inv[3] = inv_t ^ (xin[0] & xin[3]) ^ (xin[1] & xin[3]) ^ (xin[2] & xin[3]);

    assign qmh = gf4_mul(ah, inv);
    assign qml = gf4_mul(ah ^ al, inv);

    // inverse map back to GF(2^8)
    assign qm_a  = qml[1] ^ qmh[3];
    assign qm_b  = qmh[0] ^ qmh[1];
    assign gf[0] = qml[0] ^ qmh[0];
    assign gf[1] = qm_b ^ qmh[3];
    assign gf[2] = qm_a ^ qm_b;
    assign gf[3] = qm_b ^ qml[1] ^ qmh[2];
    assign gf[4] = qm_a ^ qm_b ^ qml[3];
    assign gf[5] = qm_b ^ qml[2];
    assign gf[6] = qm_a ^ qml[2] ^ qml[3] ^ qmh[0];
    assign gf[7] = qm_b ^ qml[2] ^ qmh[3];

    // affine transform, constant 0x63 flips bits 0, 1, 5 and 6
    assign out_o[0] = ~gf[0] ^ gf[4] ^ gf[5] ^ gf[6] ^ gf[7];
    assign out_o[1] = ~gf[1] ^ gf[5] ^ gf[6] ^ gf[7] ^ gf[0];
    assign out_o[2] = gf[2] ^ gf[6] ^ gf[7] ^ gf[0] ^ gf[1];
    assign out_o[3] = gf[3] ^ gf[7] ^ gf[0] ^ gf[1] ^ gf[2];
    assign out_o[4] = gf[4] ^ gf[0] ^ gf[1] ^ gf[2] ^ gf[3];
    assign out_o[5] = ~gf[5] ^ gf[1] ^ gf[2] ^ gf[3] ^ gf[4];
    assign out_o[6] = ~gf[6] ^ gf[2] ^ gf[3] ^ gf[4] ^ gf[5];
    assign out_o[7] = gf[7] ^ gf[3] ^ gf[4] ^ gf[5] ^ gf[6];

endmodule

/* src/aes_round.sv */
// One combinational AES cipher round, mix columns bypassed when final_i is set
`timescale 1ns/100ps
module aes_round (
    input  aes_pkg::aes_block_t state_i,
    input  aes_pkg::aes_block_t round_key_i,
    input  logic                final_i,
    output aes_pkg::aes_block_t state_o
);

    function automatic logic [aes_pkg::BYTE_W-1:0] xtime(
        input logic [aes_pkg::BYTE_W-1:0] b
    );
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    aes_pkg::aes_block_t sub_bytes;
    aes_pkg::aes_block_t shifted;
    aes_pkg::aes_block_t mixed;

    for (genvar i = 0; i < aes_pkg::BLOCK_W / aes_pkg::BYTE_W; i++) begin : g_sbox
        aes_sbox u_sbox (
            .in_i  (state_i[i]),
            .out_o (sub_bytes[i])
        );
    end

    // state is column-major, byte 4*col + row
    for (genvar c = 0; c < 4; c++) begin : g_col
        logic [aes_pkg::BYTE_W-1:0] col_sum;

        // row r rotates left by r columns
        for (genvar r = 0; r < 4; r++) begin : g_shift
            assign shifted[4*c + r] = sub_bytes[4*((c + r) % 4) + r];
        end

        assign col_sum = shifted[4*c] ^ shifted[4*c + 1] ^ shifted[4*c + 2] ^ shifted[4*c + 3];

        // 2*b[r] + 3*b[r+1] + b[r+2] + b[r+3] rewritten around the column sum
        for (genvar r = 0; r < 4; r++) begin : g_mix
            assign mixed[4*c + r] = shifted[4*c + r] ^ col_sum
                                  ^ xtime(shifted[4*c + r] ^ shifted[4*c + (r + 1) % 4]);
        end
    end

    assign state_o = (final_i ? shifted : mixed) ^ round_key_i;

endmodule

/* src/aes_key_expand.sv */
// AES-128 key schedule step, next round key from the current key and its round constant
`timescale 1ns/100ps
module aes_key_expand (
    input  aes_pkg::aes_block_t        key_i,
    input  logic [aes_pkg::BYTE_W-1:0] rcon_i,
    output aes_pkg::aes_block_t        key_o
);

    aes_pkg::aes_word_t         w_in  [4];
    aes_pkg::aes_word_t         w_out [4];
    aes_pkg::aes_word_t         temp;
    logic [3:0][aes_pkg::BYTE_W-1:0] sub_word;

    for (genvar k = 0; k < 4; k++) begin : g_word
        assign w_in[k] = key_i[4*k +: 4];

        // rotated last column, byte 13 lands in the top byte
        aes_sbox u_sbox (
            .in_i  (key_i[12 + (k + 1) % 4]),
            .out_o (sub_word[3 - k])
        );

        assign key_o[4*k +: 4] = w_out[k];
    end

    assign temp = {sub_word[3] ^ rcon_i, sub_word[2], sub_word[1], sub_word[0]};

    // each word chains off the one before it
    always_comb begin
        w_out[0] = w_in[0] ^ temp;
        w_out[1] = w_in[1] ^ w_out[0];
        w_out[2] = w_in[2] ^ w_out[1];
        w_out[3] = w_in[3] ^ w_out[2];
    end

endmodule

/* src/aes_core.sv */
// Iterative AES-128 engine, whitening at load then one round per clock for ten clocks
`timescale 1ns/100ps
module aes_core (
    input  logic                clock_clk,
    input  logic                reset_reset,
    input  logic                start_i,
    input  aes_pkg::aes_block_t ptext_i,
    input  aes_pkg::aes_block_t key_i,
    output logic                busy_o,
    output logic                done_o,
    output aes_pkg::aes_block_t ctext_o
);

    aes_pkg::core_state_e       state_q;
    aes_pkg::aes_block_t        block_q;
    aes_pkg::aes_block_t        rkey_q;
    aes_pkg::aes_block_t        next_key;
    aes_pkg::aes_block_t        round_out;
    logic [3:0]                 round_q;
    logic [aes_pkg::BYTE_W-1:0] rcon_q;
    logic                       last_round;
    logic                       done_q;

    assign last_round = (round_q == 4'(aes_pkg::NUM_ROUNDS));

    aes_key_expand u_key_expand (
        .key_i  (rkey_q),
        .rcon_i (rcon_q),
        .key_o  (next_key)
    );

    aes_round u_round (
        .state_i     (block_q),
        .round_key_i (next_key),
        .final_i     (last_round),
        .state_o     (round_out)
    );

    always_ff @(posedge clock_clk or posedge reset_reset) begin
        if (reset_reset) begin
            state_q <= aes_pkg::IDLE;
            round_q <= '0;
            rcon_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                aes_pkg::IDLE: begin
                    if (start_i) begin
                        state_q <= aes_pkg::BUSY;
                        round_q <= 4'd1;
                        rcon_q  <= aes_pkg::RCON_FIRST;
                    end
                end
                aes_pkg::BUSY: begin
                    round_q <= round_q + 4'd1;
                    // rcon doubles in GF(2^8) each round
                    rcon_q  <= {rcon_q[6:0], 1'b0} ^ (rcon_q[7] ? 8'h1b : 8'h00);
                    if (last_round) begin
                        state_q <= aes_pkg::IDLE;
                        done_q  <= 1'b1;
                    end
                end
            endcase
        end
    end

    // datapath, round 0 AddRoundKey folded into the load
    always_ff @(posedge clock_clk) begin
        if (state_q == aes_pkg::IDLE && start_i) begin
            block_q <= ptext_i ^ key_i;
            rkey_q  <= key_i;
        end else if (state_q == aes_pkg::BUSY) begin
            block_q <= round_out;
            rkey_q  <= next_key;
        end
    end

    assign busy_o  = (state_q == aes_pkg::BUSY);
    assign done_o  = done_q;
    assign ctext_o = block_q;

endmodule

/* src/aes_apb_regs.sv */
// APB register block holding plaintext, key, control, status and the captured ciphertext
`timescale 1ns/100ps
module aes_apb_regs (
    input  logic                clock_clk,
    input  logic                reset_reset,
    input  aes_pkg::apb_req_t   apb_i,
    output aes_pkg::aes_word_t  prdata_o,
    input  logic                busy_i,
    input  logic                done_i,
    input  aes_pkg::aes_block_t ctext_i,
    output logic                start_o,
    output aes_pkg::aes_block_t ptext_o,
    output aes_pkg::aes_block_t key_o
);

    aes_pkg::aes_reg_e   reg_sel;
    aes_pkg::aes_block_t ptext_q;
    aes_pkg::aes_block_t key_q;
    aes_pkg::aes_block_t ctext_q;
    aes_pkg::aes_word_t  rdata;
    logic                wr_en;
    logic                rd_setup;
    logic                start_q;
    logic                done_q;
    logic                busy_any;

    assign reg_sel  = aes_pkg::aes_reg_e'(apb_i.addr);
    assign wr_en    = apb_i.sel & apb_i.enable & apb_i.write;
    assign rd_setup = apb_i.sel & ~apb_i.enable & ~apb_i.write;
    // a start still waiting for the core already counts as busy
    assign busy_any = busy_i | start_q;

    always_ff @(posedge clock_clk or posedge reset_reset) begin
        if (reset_reset) begin
            ptext_q <= '0;
            key_q   <= '0;
            ctext_q <= '0;
            start_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (done_i) begin
                ctext_q <= ctext_i;
                done_q  <= 1'b1;
            end
            if (wr_en) begin
                case (reg_sel)
                    aes_pkg::PTEXT0: ptext_q[12 +: 4] <= apb_i.wdata;
                    aes_pkg::PTEXT1: ptext_q[8 +: 4]  <= apb_i.wdata;
                    aes_pkg::PTEXT2: ptext_q[4 +: 4]  <= apb_i.wdata;
                    aes_pkg::PTEXT3: ptext_q[0 +: 4]  <= apb_i.wdata;
                    aes_pkg::KEY0:   key_q[12 +: 4]   <= apb_i.wdata;
                    aes_pkg::KEY1:   key_q[8 +: 4]    <= apb_i.wdata;
                    aes_pkg::KEY2:   key_q[4 +: 4]    <= apb_i.wdata;
                    aes_pkg::KEY3:   key_q[0 +: 4]    <= apb_i.wdata;
                    aes_pkg::CTRL: begin
                        if (apb_i.wdata[0] && !busy_any) begin
                            start_q <= 1'b1;
                            done_q  <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rdata = '0;
        case (reg_sel)
            aes_pkg::PTEXT0: rdata = ptext_q[12 +: 4];
            aes_pkg::PTEXT1: rdata = ptext_q[8 +: 4];
            aes_pkg::PTEXT2: rdata = ptext_q[4 +: 4];
            aes_pkg::PTEXT3: rdata = ptext_q[0 +: 4];
            aes_pkg::KEY0:   rdata = key_q[12 +: 4];
            aes_pkg::KEY1:   rdata = key_q[8 +: 4];
            aes_pkg::KEY2:   rdata = key_q[4 +: 4];
            aes_pkg::KEY3:   rdata = key_q[0 +: 4];
            aes_pkg::CTEXT0: rdata = ctext_q[12 +: 4];
            aes_pkg::CTEXT1: rdata = ctext_q[8 +: 4];
            aes_pkg::CTEXT2: rdata = ctext_q[4 +: 4];
            aes_pkg::CTEXT3: rdata = ctext_q[0 +: 4];
            aes_pkg::STATUS: rdata[1:0] = {done_q, busy_any};
            default: ;
        endcase
    end

    // read data sampled in the setup phase, held through the access phase
    always_ff @(posedge clock_clk or posedge reset_reset) begin
        if (reset_reset) begin
            prdata_o <= '0;
        end else if (rd_setup) begin
            prdata_o <= rdata;
        end
    end

    assign start_o = start_q;
    assign ptext_o = ptext_q;
    assign key_o   = key_q;

endmodule

/* src/aes_apb_top.sv */
// Top level of the AES-128 APB peripheral, register block driving the iterative core
`timescale 1ns/100ps
module aes_apb_top (
    input  logic                      clock_clk,
    input  logic                      reset_reset,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  logic [aes_pkg::ADDR_W-1:0] paddr_i,
    input  aes_pkg::aes_word_t        pwdata_i,
    output aes_pkg::aes_word_t        prdata_o,
    output logic                      pready_o
);

    aes_pkg::apb_req_t   apb_req;
    aes_pkg::aes_block_t ptext;
    aes_pkg::aes_block_t key;
    aes_pkg::aes_block_t ctext;
    logic                start;
    logic                busy;
    logic                done;

    assign apb_req = '{sel: psel_i, enable: penable_i, write: pwrite_i,
                       addr: paddr_i, wdata: pwdata_i};

    // zero wait states
    assign pready_o = 1'b1;

    aes_apb_regs u_regs (
        .clock_clk   (clock_clk),
        .reset_reset (reset_reset),
        .apb_i       (apb_req),
        .prdata_o    (prdata_o),
        .busy_i      (busy),
        .done_i      (done),
        .ctext_i     (ctext),
        .start_o     (start),
        .ptext_o     (ptext),
        .key_o       (key)
    );

    aes_core u_core (
        .clock_clk   (clock_clk),
        .reset_reset (reset_reset),
        .start_i     (start),
        .ptext_i     (ptext),
        .key_i       (key),
        .busy_o      (busy),
        .done_o      (done),
        .ctext_o     (ctext)
    );

endmodule

/* sim/aes_apb_tb.sv */
// Testbench for the AES-128 APB peripheral, drives register accesses and checks known vectors
`timescale 1ns/100ps
module aes_apb_tb;

    localparam int POLL_CYCLES = 50;
    // about 350 cycles of bus traffic, rounded up and tripled
    localparam int TEST_CYCLES     = 1000;
    localparam int WATCHDOG_CYCLES = 3 * TEST_CYCLES;

    // FIPS-197 appendix B and C.1 vectors
    localparam logic [127:0] PT_B   = 128'h3243f6a8885a308d313198a2e0370734;
    localparam logic [127:0] KEY_B  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam logic [127:0] CT_B   = 128'h3925841d02dc09fbdc118597196a0b32;
    localparam logic [127:0] PT_C1  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] KEY_C1 = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] CT_C1  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic        clock_clk = 1'b0;
    logic        reset_reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [5:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;

    int          errors      = 0;
    int          checks      = 0;
    int          cycle_count = 0;
    logic [31:0] lcg_state   = 32'd4;
    logic [31:0] rand_words [8];
    logic [31:0] rd_word;

    aes_apb_top uut (
        .clock_clk   (clock_clk),
        .reset_reset (reset_reset),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .paddr_i     (paddr),
        .pwdata_i    (pwdata),
        .prdata_o    (prdata),
        .pready_o    (pready)
    );

    always #4 clock_clk = ~clock_clk;

    always @(posedge clock_clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // setup phase then access phase, one idle cycle afterwards
    task automatic apb_write(input logic [5:0] addr, input logic [31:0] data);
        @(negedge clock_clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clock_clk);
        penable = 1'b1;
        check_word("pready on write", 32'h1, {31'b0, pready});
        @(negedge clock_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // prdata is registered at the setup edge and held through the access phase
    task automatic apb_read(input logic [5:0] addr, output logic [31:0] data);
        @(negedge clock_clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clock_clk);
        penable = 1'b1;
        data    = prdata;
        check_word("pready on read", 32'h1, {31'b0, pready});
        @(negedge clock_clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // word at base + 4*i carries block bits [32*i +: 32]
    task automatic write_block(input logic [5:0] base, input logic [127:0] blk);
        for (int i = 0; i < 4; i++) begin
            apb_write(base + 6'(4 * i), blk[32*i +: 32]);
        end
    endtask

    task automatic check_block(input string name, input logic [5:0] base, input logic [127:0] exp);
        logic [31:0] data;
        for (int i = 0; i < 4; i++) begin
            apb_read(base + 6'(4 * i), data);
            check_word($sformatf("%s word %0d", name, i), exp[32*i +: 32], data);
        end
    endtask

    task automatic start_cipher();
        apb_write(aes_pkg::CTRL, 32'h1);
    endtask

    task automatic wait_done(input string name);
        logic [31:0] status;
        int          first_cycle;
        first_cycle = cycle_count;
        status      = '0;
        while (status[1] !== 1'b1 && cycle_count - first_cycle <= POLL_CYCLES) begin
            apb_read(aes_pkg::STATUS, status);
        end
        if (status[1] !== 1'b1) begin
            $display("%s: done bit still clear after %0d cycles of polling", name, POLL_CYCLES);
            errors++;
        end
    endtask

    initial begin
        reset_reset = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        repeat (3) @(posedge clock_clk);
        @(negedge clock_clk);
        reset_reset = 1'b0;

        // reset values
        apb_read(aes_pkg::STATUS, rd_word);
        check_word("reset status", 32'h0, rd_word);
        check_block("reset ctext", aes_pkg::CTEXT0, '0);
        check_block("reset ptext", aes_pkg::PTEXT0, '0);
        check_block("reset key", aes_pkg::KEY0, '0);

        // plaintext and key words sit at offsets 0 to 28
        for (int i = 0; i < 8; i++) begin
            rand_words[i] = lcg_next();
            apb_write(6'(4 * i), rand_words[i]);
        end
        for (int i = 0; i < 8; i++) begin
            apb_read(6'(4 * i), rd_word);
            check_word($sformatf("readback offset %0d", 4 * i), rand_words[i], rd_word);
        end
        apb_write(aes_pkg::CTEXT1, lcg_next());
        apb_read(aes_pkg::CTEXT1, rd_word);
        check_word("ctext read only", 32'h0, rd_word);
        apb_read(6'd60, rd_word);
        check_word("unmapped offset", 32'h0, rd_word);

        write_block(aes_pkg::PTEXT0, PT_B);
        write_block(aes_pkg::KEY0, KEY_B);
        start_cipher();
        wait_done("vector B");
        check_block("vector B", aes_pkg::CTEXT0, CT_B);

        write_block(aes_pkg::PTEXT0, PT_C1);
        write_block(aes_pkg::KEY0, KEY_C1);
        start_cipher();
        wait_done("vector C1");
        check_block("vector C1", aes_pkg::CTEXT0, CT_C1);

        // a second start while busy would pick up the altered plaintext
        start_cipher();
        apb_read(aes_pkg::STATUS, rd_word);
        check_word("busy status", 32'h1, rd_word);
        apb_write(aes_pkg::PTEXT0, lcg_next());
        // second CTRL write lands on the tenth round edge, the last one with busy set
        repeat (2) @(negedge clock_clk);
        start_cipher();
        wait_done("start while busy");
        apb_read(aes_pkg::STATUS, rd_word);
        check_word("done status", 32'h2, rd_word);
        check_block("start while busy", aes_pkg::CTEXT0, CT_C1);

        // new inputs after done, result holds until the next start
        write_block(aes_pkg::PTEXT0, PT_B);
        write_block(aes_pkg::KEY0, KEY_B);
        check_block("ctext held", aes_pkg::CTEXT0, CT_C1);
        start_cipher();
        wait_done("restart");
        check_block("restart", aes_pkg::CTEXT0, CT_B);

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock_clk);
        $display("watchdog expired after %0d cycles, test sequence did not finish",
                 WATCHDOG_CYCLES);
        $display("checks run: %0d, errors: %0d", checks, errors);
        $display("Checks failed");
        $finish;
    end

endmodule

/* src.f */
src/aes_pkg.sv
src/aes_sbox.sv
src/aes_round.sv
src/aes_key_expand.sv
src/aes_core.sv
src/aes_apb_regs.sv
src/aes_apb_top.sv
sim/aes_apb_tb.sv

/* Makefile */
TOP = aes_apb_tb
LOG = sim.log

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
